// File: verif/iterator_cases.txt
// ll_x ll_y ur_x ur_y (hex, 24-bit, 10 fraction bits) msaa (hex one-hot)
// tri_tag color_tag (hex) walk_cycles (decimal)
000000 000000 000800 000800 8 000100 0a0000 3
000000 000000 000800 000800 4 000200 0b0000 10
000400 000400 000800 000c00 2 000300 0c0000 15
000000 000000 000200 000200 1 000400 0d0000 10
000c00 000c00 000c00 000c00 8 000500 0e0000 1
000000 000000 000600 000400 8 000600 0f0000 3
fff800 fffc00 000000 000400 4 000700 100000 10
000000 000000 000400 001000 8 000800 110000 4

// File: test_iterator.f
logic/raster_pkg.sv
logic/bbox_walker.sv
logic/sample_lane.sv
logic/sample_collector.sv
logic/test_iterator.sv
verif/tb_test_iterator.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the iterator testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_test_iterator -f test_iterator.f -o tb_test_iterator \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_test_iterator > sim.log 2>&1
cat sim.log

grep -q "Finished with errors" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "Finished with no errors" sim.log && echo "simulation PASSED" \
    || { echo "simulation gave no result"; exit 1; }

// File: verif/tb_test_iterator.sv
// testbench for the sample iterator with case file, reference walk and per-cycle checks
`timescale 1ns/10ps

module tb_test_iterator;
    import raster_pkg::*;

    localparam int MAX_CASES = 32;
    localparam string CASE_FILE = "verif/iterator_cases.txt";

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    tri_valid;
    logic                    halt;
    tri_t                    tri_in;
    tri_t                    tri_out;
    tri_color_t              color_in;
    tri_color_t              color_out;
    bbox_t                   box_in;
    msaa_e                   sub_sample;
    sample_t [NUM_LANES-1:0] samples;

    // case table with one entry per file line
    int         ll_x[MAX_CASES], ll_y[MAX_CASES], ur_x[MAX_CASES], ur_y[MAX_CASES];
    int         tri_tag[MAX_CASES], color_tag[MAX_CASES], file_len[MAX_CASES];
    logic [3:0] msaa[MAX_CASES];
    int         num_cases;

    // reference walk of the current case
    int walk_x[$];
    int walk_base[$];
    int walk_step;

    integer seed = 62;
    int     error_count = 0;
    int     cycle_count = 0;
    int     cycle_limit = 0;

    test_iterator DUT (.*);

    always #5 clk = ~clk;

    // run limit from the predicted walk lengths
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("timeout: no result after %0d cycles", cycle_count);
            $display("Finished with errors");
            $fatal(1, "run did not finish in time");
        end
    end

    task automatic compare_value(input string name, input integer got, input integer exp);
        if (got !== exp) begin
            error_count++;
            $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            $display("Finished with errors");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic read_cases();
        integer fd, n;
        string line;
        logic [23:0] f_llx, f_lly, f_urx, f_ury, f_tri, f_col;
        logic [3:0] f_msaa;
        integer f_len;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("could not open the case file %s", CASE_FILE);
            $display("Finished with errors");
            $fatal(1, "no case file");
        end
        num_cases = 0;
        while (!$feof(fd) && num_cases < MAX_CASES) begin
            n = $fgets(line, fd);
            // comment and blank lines give fewer fields
            if (n > 0 && $sscanf(line, "%h %h %h %h %h %h %h %d", f_llx, f_lly, f_urx, f_ury,
                                 f_msaa, f_tri, f_col, f_len) == 8) begin
                ll_x[num_cases] = 32'($signed(f_llx));
                ll_y[num_cases] = 32'($signed(f_lly));
                ur_x[num_cases] = 32'($signed(f_urx));
                ur_y[num_cases] = 32'($signed(f_ury));
                msaa[num_cases] = f_msaa;
                tri_tag[num_cases] = 32'(f_tri);
                color_tag[num_cases] = 32'(f_col);
                file_len[num_cases] = f_len;
                num_cases++;
            end
        end
        $fclose(fd);
        if (num_cases == 0) begin
            $display("the case file holds no cases");
            $display("Finished with errors");
            $fatal(1, "empty case file");
        end
    endtask

    // walk steps right and returns to left edge with base up four steps
    task automatic build_walk(input int c, output int len);
        int x, base;
        bit done;
        walk_step = 32'(msaa[c]) << (RADIX - 3);
        x = ll_x[c];
        base = ll_y[c];
        done = 1'b0;
        walk_x.delete();
        walk_base.delete();
        while (!done && walk_x.size() < 4096) begin
            walk_x.push_back(x);
            walk_base.push_back(base);
            if (x >= ur_x[c] && base + (NUM_LANES - 1) * walk_step >= ur_y[c]) begin
                done = 1'b1;
            end else if (x >= ur_x[c]) begin
                x = ll_x[c];
                base = base + NUM_LANES * walk_step;
            end else begin
                x = x + walk_step;
            end
        end
        len = walk_x.size();
    endtask

    task automatic expect_idle();
        compare_value("halt", 32'(halt), 0);
        for (int i = 0; i < NUM_LANES; i++) begin
            compare_value($sformatf("samples[%0d].valid", i), 32'(samples[i].valid), 0);
        end
    endtask

    // outputs after edge k of a walk where edge 0 accepts
    task automatic verify_step(input int c, input int k, input int len);
        int r, y, v;
        compare_value("halt", 32'(halt), (k <= len - 1) ? 1 : 0);
        if (k >= 2 && k <= len + 1) begin
            r = k - 2;
            for (int i = 0; i < NUM_LANES; i++) begin
                y = walk_base[r] + i * walk_step;
                v = (walk_x[r] <= ur_x[c] && y <= ur_y[c]) ? 1 : 0;
                compare_value($sformatf("samples[%0d].x", i), 32'($signed(samples[i].x)),
                              walk_x[r]);
                compare_value($sformatf("samples[%0d].y", i), 32'($signed(samples[i].y)), y);
                compare_value($sformatf("samples[%0d].valid", i), 32'(samples[i].valid), v);
            end
            for (int vt = 0; vt < NUM_VERTS; vt++) begin
                for (int a = 0; a < NUM_AXIS; a++) begin
                    compare_value($sformatf("tri_out.vert[%0d][%0d]", vt, a),
                                  32'($signed(tri_out.vert[vt][a])),
                                  tri_tag[c] + vt * NUM_AXIS + a);
                end
            end
            for (int ch = 0; ch < NUM_COLORS; ch++) begin
                compare_value($sformatf("color_out.chan[%0d]", ch), 32'(color_out.chan[ch]),
                              color_tag[c] + 16 * ch);
            end
        end else begin
            for (int i = 0; i < NUM_LANES; i++) begin
                compare_value($sformatf("samples[%0d].valid", i), 32'(samples[i].valid), 0);
            end
        end
    endtask

    task automatic run_case(input int c);
        int gap, len;
        tri_t t;
        tri_color_t col;
        bbox_t b;
        build_walk(c, len);
        gap = $random(seed) & 3;
        repeat (gap) begin
            @(posedge clk);
            @(negedge clk);
            expect_idle();
        end
        for (int vt = 0; vt < NUM_VERTS; vt++) begin
            for (int a = 0; a < NUM_AXIS; a++) begin
                t.vert[vt][a] = coord_t'(tri_tag[c] + vt * NUM_AXIS + a);
            end
        end
        for (int ch = 0; ch < NUM_COLORS; ch++) begin
            col.chan[ch] = color_t'(color_tag[c] + 16 * ch);
        end
        b.ll_x = coord_t'(ll_x[c]);
        b.ll_y = coord_t'(ll_y[c]);
        b.ur_x = coord_t'(ur_x[c]);
        b.ur_y = coord_t'(ur_y[c]);
        @(posedge clk);
        box_in <= b;
        tri_in <= t;
        color_in <= col;
        sub_sample <= msaa_e'(msaa[c]);
        tri_valid <= 1'b1;
        @(negedge clk);
        expect_idle();
        for (int k = 0; k <= len + 2; k++) begin
            @(posedge clk);
            // stray strobes while the walker still sits in its walk
            if (k >= 1 && k <= len - 1) begin
                tri_valid <= (($random(seed) & 1) != 0);
            end else begin
                tri_valid <= 1'b0;
            end
            @(negedge clk);
            verify_step(c, k, len);
        end
    endtask

    initial begin
        int len;
        int total_len;
        rst = 1'b1;
        tri_valid = 1'b0;
        tri_in = '0;
        color_in = '0;
        box_in = '0;
        sub_sample = MSAA_1X;
        read_cases();
        total_len = 0;
        for (int c = 0; c < num_cases; c++) begin
            build_walk(c, len);
            compare_value($sformatf("walk length of case %0d", c), len, file_len[c]);
            total_len += len;
        end
        cycle_limit = 2 * total_len + 20 * num_cases;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        expect_idle();
        for (int c = 0; c < num_cases; c++) begin
            run_case(c);
        end
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: logic/test_iterator.sv
// bounding-box sample iterator built from walker, stacked sample lanes and output collector
`timescale 1ns/10ps

module test_iterator (
    input  logic                                                clk,
    input  logic                                                rst,
    input  raster_pkg::tri_t                                    tri_in,
    input  raster_pkg::tri_color_t                              color_in,
    input  raster_pkg::bbox_t                                   box_in,
    input  logic                                                tri_valid,
    input  raster_pkg::msaa_e                                   sub_sample,
    output raster_pkg::tri_t                                    tri_out,
    output raster_pkg::tri_color_t                              color_out,
    output raster_pkg::sample_t [raster_pkg::NUM_LANES-1:0]     samples,
    output logic                                                halt
);
    import raster_pkg::*;

    row_t                    row;
    logic                    accept;
    sample_t [NUM_LANES-1:0] lane_samples;

    // walk control
    bbox_walker u_walker (
        .clk        (clk),
        .rst        (rst),
        .tri_valid  (tri_valid),
        .box_in     (box_in),
        .sub_sample (sub_sample),
        .row        (row),
        .accept     (accept),
        .halt       (halt)
    );

    // one lane per stacked sample
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        sample_lane #(
            .LANE_INDEX (i)
        ) u_lane (
            .clk    (clk),
            .rst    (rst),
            .row    (row),
            .sample (lane_samples[i])
        );
    end

    sample_collector u_collector (
        .clk          (clk),
        .rst          (rst),
        .accept       (accept),
        .tri_in       (tri_in),
        .color_in     (color_in),
        .lane_samples (lane_samples),
        .tri_out      (tri_out),
        .color_out    (color_out),
        .samples      (samples)
    );

endmodule

// File: logic/sample_collector.sv
// sample collector aligning triangle and colour of the walk with the lane samples
`timescale 1ns/10ps

module sample_collector (
    input  logic                                                clk,
    input  logic                                                rst,
    input  logic                                                accept,
    input  raster_pkg::tri_t                                    tri_in,
    input  raster_pkg::tri_color_t                              color_in,
    input  raster_pkg::sample_t [raster_pkg::NUM_LANES-1:0]     lane_samples,
    output raster_pkg::tri_t                                    tri_out,
    output raster_pkg::tri_color_t                              color_out,
    output raster_pkg::sample_t [raster_pkg::NUM_LANES-1:0]     samples
);
    import raster_pkg::*;

    // captured while upstream is held
    tri_t       tri_cap;
    tri_color_t color_cap;

    sample_t [NUM_LANES-1:0] samp_q;

    always_ff @(posedge clk) begin
        if (accept) begin
            tri_cap <= tri_in;
            color_cap <= color_in;
        end
        // one more stage to line up with the lanes
        tri_out <= tri_cap;
        color_out <= color_cap;
    end

    // lane samples in step with tri_out
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            samp_q <= '0;
        end else begin
            samp_q <= lane_samples;
        end
    end

    assign samples = samp_q;

endmodule

// File: logic/sample_lane.sv
// sample lane that places one sample at its row offset and flags it when inside the box
`timescale 1ns/10ps

module sample_lane #(
    parameter int LANE_INDEX = 0
) (
    input  logic                clk,
    input  logic                rst,
    input  raster_pkg::row_t    row,
    output raster_pkg::sample_t sample
);
    import raster_pkg::*;

    coord_t lane_y;
    logic   in_box;

    coord_t x_q;
    coord_t y_q;
    logic   valid_q;

    // LANE_INDEX steps above the row base
    assign lane_y = row.base_y + coord_t'(LANE_INDEX) * row.step;

    // inclusive on the upper-right edges
    // lower-left is met by the walk start
    assign in_box = (row.x <= row.ur_x) && (lane_y <= row.ur_y);

    // position payload
    always_ff @(posedge clk) begin
        x_q <= row.x;
        y_q <= lane_y;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= row.live && in_box;
        end
    end

    always_comb begin
        sample.x = x_q;
        sample.y = y_q;
        sample.valid = valid_q;
    end

    // a flagged sample lies inside the box of the previous row
    assert property (@(posedge clk) disable iff (rst)
        sample.valid |-> (sample.x <= $past(row.ur_x)) && (sample.y <= $past(row.ur_y)));

endmodule

// File: logic/bbox_walker.sv
// bounding-box walker that latches the box on accept, steps columns and rows and holds upstream
`timescale 1ns/10ps

module bbox_walker (
    input  logic                clk,
    input  logic                rst,
    input  logic                tri_valid,
    input  raster_pkg::bbox_t   box_in,
    input  raster_pkg::msaa_e   sub_sample,
    output raster_pkg::row_t    row,
    output logic                accept,
    output logic                halt
);
    import raster_pkg::*;

    iter_state_e state;
    iter_state_e state_next;

    // latched walk parameters
    bbox_t  box_q;
    coord_t step_q;

    // current column and row base
    coord_t col_x;
    coord_t base_y;

    // helpers
    coord_t step_in;
    coord_t top_y;
    logic   at_right;
    logic   at_top;
    logic   at_end;
    logic   take;

    // interval from the one-hot code
    assign step_in = coord_t'(sub_sample) << (RADIX - 3);

    // only sampled while idle
    assign take = (state == ITER_WAIT) && tri_valid;

    // top lane sits NUM_LANES-1 steps above the base
    assign top_y = base_y + coord_t'(NUM_LANES - 1) * step_q;
    assign at_right = (col_x >= box_q.ur_x);
    assign at_top = (top_y >= box_q.ur_y);
    assign at_end = at_right && at_top;

    always_comb begin
        state_next = state;
        case (state)
            ITER_WAIT: begin
                if (tri_valid) begin
                    state_next = ITER_TEST;
                end
            end
            ITER_TEST: begin
                if (at_end) begin
                    state_next = ITER_WAIT;
                end
            end
            default: state_next = ITER_WAIT;
        endcase
    end

    // control state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ITER_WAIT;
            halt <= 1'b0;
            accept <= 1'b0;
        end else begin
            state <= state_next;
            halt <= (state_next == ITER_TEST);
            // one cycle after the accepting edge
            accept <= take;
        end
    end

    // walk position
    always_ff @(posedge clk) begin
        if (take) begin
            box_q <= box_in;
            step_q <= step_in;
            col_x <= box_in.ll_x;
            base_y <= box_in.ll_y;
        end else if (state == ITER_TEST) begin
            if (at_right) begin
                // back to left edge with base up a full lane group
                col_x <= box_q.ll_x;
                base_y <= base_y + coord_t'(NUM_LANES) * step_q;
            end else begin
                col_x <= col_x + step_q;
            end
        end
    end

    always_comb begin
        row.x = col_x;
        row.base_y = base_y;
        row.step = step_q;
        row.ur_x = box_q.ur_x;
        row.ur_y = box_q.ur_y;
        row.live = (state == ITER_TEST);
    end

    // accept always starts a walk
    assert property (@(posedge clk) disable iff (rst)
        (state == ITER_WAIT && tri_valid) |=> (state == ITER_TEST));

    // end of box always returns to idle
    assert property (@(posedge clk) disable iff (rst)
        (state == ITER_TEST && at_end) |=> (state == ITER_WAIT));

    // halt tracks the walk exactly
    assert property (@(posedge clk) disable iff (rst)
        halt == (state == ITER_TEST));

endmodule

// File: logic/raster_pkg.sv
// raster iterator package with fixed-point widths, MSAA codes, FSM states and shared bundles
package raster_pkg;

    // fixed-point format with integer part above RADIX
    localparam int SIGFIG = 24;
    localparam int RADIX = 10;

    // samples per step, stacked vertically
    localparam int NUM_LANES = 4;

    // triangle shape
    localparam int NUM_VERTS = 3;
    localparam int NUM_AXIS = 3;
    localparam int NUM_COLORS = 3;

    // signed coordinate with RADIX fraction bits
    typedef logic signed [SIGFIG-1:0] coord_t;

    // unsigned colour channel
    typedef logic [SIGFIG-1:0] color_t;

    // one-hot multisample code
    // shifted by RADIX-3 it gives the sample interval
    typedef enum logic [3:0] {
        MSAA_1X  = 4'b1000,
        MSAA_4X  = 4'b0100,
        MSAA_16X = 4'b0010,
        MSAA_64X = 4'b0001
    } msaa_e;

    // walker FSM
    typedef enum logic {
        ITER_WAIT,
        ITER_TEST
    } iter_state_e;

    // lower-left and upper-right corners
    typedef struct packed {
        coord_t ll_x;
        coord_t ll_y;
        coord_t ur_x;
        coord_t ur_y;
    } bbox_t;

    // vertex by axis
    typedef struct packed {
        coord_t [NUM_VERTS-1:0][NUM_AXIS-1:0] vert;
    } tri_t;

    typedef struct packed {
        color_t [NUM_COLORS-1:0] chan;
    } tri_color_t;

    // one column position handed to the lanes
    typedef struct packed {
        coord_t x;
        coord_t base_y;
        coord_t step;
        coord_t ur_x;
        coord_t ur_y;
        logic   live;
    } row_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   valid;
    } sample_t;

endpackage
